/* fixp_pkg.sv */
package fixp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Signed Q8.8 number format
	////////////////////////////////////////////////////////////////////////////

	// One matrix element, 8 integer and 8 fraction bits
	typedef logic signed [15:0] elem_t;

	// Products and pre-shifted dividends
	typedef logic signed [31:0] wide_t;

	localparam int FRAC_BITS = 8;

	// 1.0 on the diagonal of the identity half
	localparam elem_t ONE = elem_t'(1 << FRAC_BITS);

endpackage

/* matrix_pkg.sv */
package matrix_pkg;

	import fixp_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Stream beats
	////////////////////////////////////////////////////////////////////////////

	// One element of A, row-major
	typedef struct packed
	{
		elem_t elem;
	} in_beat_t;

	// One element of the inverse
	typedef struct packed
	{
		logic  singular;
		elem_t elem;
	} out_beat_t;

endpackage

/* row_divider.sv */
`timescale 1ns/10ps

module row_divider
	import fixp_pkg::*;
#(
	parameter int n = 5
)
(
	input  elem_t [2*n-1:0] pivot_row,
	input  elem_t           pivot,
	output elem_t [2*n-1:0] norm_row
);

	wide_t divisor;

	assign divisor = wide_t'(pivot);

	// One fixed-point quotient per column of the augmented row
	for (genvar i = 0; i < 2*n; i++)
	begin : g_col
		wide_t dividend;
		wide_t quotient;

		// Pre-shift keeps the fraction bits of the quotient
		assign dividend = wide_t'(pivot_row[i]) <<< FRAC_BITS;

		// Signed divide truncates toward zero
		assign quotient = dividend / divisor;

		assign norm_row[i] = elem_t'(quotient[15:0]);
	end

endmodule

/* row_eliminator.sv */
`timescale 1ns/10ps

module row_eliminator
	import fixp_pkg::*;
#(
	parameter int n = 5
)
(
	input  elem_t [2*n-1:0] pivot_row,
	input  elem_t [2*n-1:0] target_row,
	input  elem_t           factor,
	output elem_t [2*n-1:0] elim_row
);

	wide_t scale;

	assign scale = wide_t'(factor);

	// target - factor * pivot, column by column
	for (genvar i = 0; i < 2*n; i++)
	begin : g_col
		wide_t product;
		wide_t scaled;

		assign product = scale * wide_t'(pivot_row[i]);

		// Back to Q8.8, rounding toward minus infinity
		assign scaled = product >>> FRAC_BITS;

		// Wraps to 16 bits
		assign elim_row[i] = target_row[i] - elem_t'(scaled[15:0]);
	end

endmodule

/* gauss_jordan_ctrl.sv */
`timescale 1ns/10ps

module gauss_jordan_ctrl
	import fixp_pkg::*;
	import matrix_pkg::*;
#(
	parameter int n = 5
)
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  in_beat_t        in_beat,
	output logic            out_valid,
	input  logic            out_ready,
	output out_beat_t       out_beat,
	output elem_t [2*n-1:0] pivot_row,
	output elem_t           pivot,
	input  elem_t [2*n-1:0] norm_row,
	output elem_t [2*n-1:0] target_row,
	output elem_t           factor,
	input  elem_t [2*n-1:0] elim_row
);

	typedef enum logic [1:0]
	{
		LOAD,
		NORMALIZE,
		ELIMINATE,
		UNLOAD
	} ctrl_state_t;

	localparam int idx_w = (n > 1) ? $clog2(n) : 1;
	localparam logic [idx_w-1:0] last_idx = idx_w'(n - 1);

	ctrl_state_t state;

	// Augmented matrix, columns 0..n-1 hold A, n..2n-1 the identity half
	elem_t [2*n-1:0] mat [n];

	// Element position for load and unload
	logic [idx_w-1:0] row_idx;
	logic [idx_w-1:0] col_idx;

	logic [idx_w-1:0] piv_idx;
	logic [idx_w-1:0] tgt_idx;
	logic             singular;

	logic             in_fire;
	logic             out_fire;
	logic             last_cell;
	logic             pivot_zero;
	logic             last_tgt;
	logic [idx_w-1:0] first_tgt;
	logic [idx_w-1:0] tgt_inc;
	logic [idx_w-1:0] next_tgt;

	////////////////////////////////////////////////////////////////////////////
	// Handshakes and step decode
	////////////////////////////////////////////////////////////////////////////

	assign in_ready  = (state == LOAD);
	assign out_valid = (state == UNLOAD);

	assign in_fire  = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;

	assign last_cell = (row_idx == last_idx) && (col_idx == last_idx);

	assign pivot_zero = (pivot == elem_t'(0));

	// Target rows run in ascending order and skip the pivot row
	assign first_tgt = (piv_idx == '0) ? idx_w'(1) : '0;
	assign tgt_inc   = tgt_idx + 1'b1;
	assign next_tgt  = (tgt_inc == piv_idx) ? tgt_inc + 1'b1 : tgt_inc;
	assign last_tgt  = (piv_idx == last_idx) ? (tgt_idx == last_idx - 1'b1)
		: (tgt_idx == last_idx);

	// Row unit operands
	assign pivot_row  = mat[piv_idx];
	assign pivot      = mat[piv_idx][piv_idx];
	assign target_row = mat[tgt_idx];
	assign factor     = mat[tgt_idx][piv_idx];

	always_comb
	begin
		out_beat.singular = singular;
		out_beat.elem     = mat[row_idx][n + col_idx];
	end

	////////////////////////////////////////////////////////////////////////////
	// Row-major position, shared by load and unload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			row_idx <= '0;
			col_idx <= '0;
		end
		else if (in_fire || out_fire)
		begin
			if (col_idx == last_idx)
			begin
				col_idx <= '0;
				row_idx <= last_cell ? '0 : row_idx + 1'b1;
			end
			else
				col_idx <= col_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= LOAD;
			piv_idx  <= '0;
			tgt_idx  <= '0;
			singular <= 1'b0;
		end
		else
		begin
			case (state)
				LOAD:
				begin
					if (in_fire && last_cell)
					begin
						piv_idx <= '0;
						state   <= NORMALIZE;
					end
				end
				NORMALIZE:
				begin
					// No pivoting, so a zero here ends the run
					if (pivot_zero)
					begin
						singular <= 1'b1;
						state    <= UNLOAD;
					end
					else if (n == 1)
						state <= UNLOAD;
					else
					begin
						tgt_idx <= first_tgt;
						state   <= ELIMINATE;
					end
				end
				ELIMINATE:
				begin
					if (!last_tgt)
						tgt_idx <= next_tgt;
					else if (piv_idx == last_idx)
						state <= UNLOAD;
					else
					begin
						piv_idx <= piv_idx + 1'b1;
						state   <= NORMALIZE;
					end
				end
				UNLOAD:
				begin
					if (out_fire && last_cell)
					begin
						singular <= 1'b0;
						state    <= LOAD;
					end
				end
				default:
					state <= LOAD;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Matrix store
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		case (state)
			LOAD:
			begin
				if (in_fire)
				begin
					mat[row_idx][col_idx]     <= in_beat.elem;
					mat[row_idx][n + col_idx] <= (row_idx == col_idx) ? ONE : elem_t'(0);
				end
			end
			NORMALIZE:
			begin
				if (!pivot_zero)
					mat[piv_idx] <= norm_row;
			end
			ELIMINATE:
				mat[tgt_idx] <= elim_row;
			default:
			begin
			end
		endcase
	end

endmodule

/* matrix_inverter.sv */
`timescale 1ns/10ps

module matrix_inverter
	import fixp_pkg::*;
	import matrix_pkg::*;
#(
	parameter int n = 5
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	output logic      in_ready,
	input  in_beat_t  in_beat,
	output logic      out_valid,
	input  logic      out_ready,
	output out_beat_t out_beat
);

	elem_t [2*n-1:0] pivot_row;
	elem_t           pivot;
	elem_t [2*n-1:0] norm_row;
	elem_t [2*n-1:0] target_row;
	elem_t           factor;
	elem_t [2*n-1:0] elim_row;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing and matrix store
	////////////////////////////////////////////////////////////////////////////

	gauss_jordan_ctrl #(
		.n(n)
	) u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_beat    (in_beat),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_beat   (out_beat),
		.pivot_row  (pivot_row),
		.pivot      (pivot),
		.norm_row   (norm_row),
		.target_row (target_row),
		.factor     (factor),
		.elim_row   (elim_row)
	);

	////////////////////////////////////////////////////////////////////////////
	// Row arithmetic, both units see the same pivot row
	////////////////////////////////////////////////////////////////////////////

	row_divider #(
		.n(n)
	) u_div (
		.pivot_row (pivot_row),
		.pivot     (pivot),
		.norm_row  (norm_row)
	);

	row_eliminator #(
		.n(n)
	) u_elim (
		.pivot_row  (pivot_row),
		.target_row (target_row),
		.factor     (factor),
		.elim_row   (elim_row)
	);

endmodule

/* tb_matrix_inverter.sv */
`timescale 1ns/10ps

module tb_matrix_inverter
	import fixp_pkg::*;
	import matrix_pkg::*;
;

	localparam int n = 5;
	localparam int limit = 200;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	in_beat_t  in_beat;
	logic      out_valid;
	logic      out_ready;
	out_beat_t out_beat;

	elem_t     mat_a [n][n];
	elem_t     exp_inv [n][n];
	bit        exp_sing;
	out_beat_t got [n*n];
	int        n_got;
	int        errors;
	int        checks;
	int        tests;

	matrix_inverter #(
		.n(n)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_beat   (in_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_beat  (out_beat)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Gauss-Jordan reference model in Q8.8 without pivoting
	////////////////////////////////////////////////////////////////////////////

	task automatic model_inverse();
		elem_t m [n][2*n];
		wide_t num;
		wide_t den;
		wide_t prod;
		elem_t f;
		exp_sing = 1'b0;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
			begin
				m[r][c]     = mat_a[r][c];
				m[r][n + c] = (r == c) ? ONE : elem_t'(0);
			end
		for (int k = 0; k < n && !exp_sing; k++)
		begin
			if (m[k][k] == elem_t'(0))
				exp_sing = 1'b1;
			else
			begin
				den = wide_t'(m[k][k]);
				for (int j = 0; j < 2*n; j++)
				begin
					num     = wide_t'(m[k][j]) <<< FRAC_BITS;
					num     = num / den;
					m[k][j] = num[15:0];
				end
				// Other rows top to bottom with the factor read before the row changes
				for (int i = 0; i < n; i++)
				begin
					if (i != k)
					begin
						f = m[i][k];
						for (int j = 0; j < 2*n; j++)
						begin
							prod    = wide_t'(f) * wide_t'(m[k][j]);
							prod    = prod >>> FRAC_BITS;
							m[i][j] = m[i][j] - prod[15:0];
						end
					end
				end
			end
		end
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				exp_inv[r][c] = m[r][n + c];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stream drivers
	////////////////////////////////////////////////////////////////////////////

	function automatic elem_t int_elem(input int v);
		return elem_t'(v <<< FRAC_BITS);
	endfunction

	task automatic set_row(input int r, input int a, input int b, input int c,
		input int d, input int e);
		mat_a[r][0] = int_elem(a);
		mat_a[r][1] = int_elem(b);
		mat_a[r][2] = int_elem(c);
		mat_a[r][3] = int_elem(d);
		mat_a[r][4] = int_elem(e);
	endtask

	// Starts and ends on a falling edge
	task automatic send_matrix(input bit gaps);
		int t;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
			begin
				if (gaps)
					repeat ($urandom % 3) @(negedge clk);
				in_valid     = 1'b1;
				in_beat.elem = mat_a[r][c];
				t = 0;
				while (!in_ready && t < limit)
				begin
					@(negedge clk);
					t++;
				end
				checks++;
				assert (in_ready)
				else
				begin
					$display("Timeout: in_ready never rose for element [%0d][%0d]", r, c);
					errors++;
				end
				if (!in_ready)
				begin
					in_valid = 1'b0;
					return;
				end
				@(negedge clk);
				in_valid = 1'b0;
			end
	endtask

	task automatic collect_matrix(input bit stall);
		int        t;
		int        hold;
		out_beat_t held;
		n_got = 0;
		for (int i = 0; i < n*n; i++)
		begin
			t = 0;
			while (!out_valid && t < limit)
			begin
				@(negedge clk);
				t++;
			end
			checks++;
			assert (out_valid)
			else
			begin
				$display("Timeout: out_valid not seen for output beat %0d", i);
				errors++;
			end
			if (!out_valid)
				return;
			hold = stall ? $urandom % 3 : 0;
			// Beat must not move while out_ready is low
			repeat (hold)
			begin
				out_ready = 1'b0;
				held      = out_beat;
				@(negedge clk);
				checks++;
				assert (out_valid && out_beat == held)
				else
				begin
					$display("FAILED %0t out_beat expected %h got %h (out_valid %b)",
						$time, held, out_beat, out_valid);
					errors++;
				end
			end
			out_ready = 1'b1;
			got[i]    = out_beat;
			n_got++;
			@(negedge clk);
			out_ready = 1'b0;
		end
		checks++;
		assert (!out_valid && in_ready)
		else
		begin
			$display("Output stream did not end after %0d beats", n*n);
			errors++;
		end
	endtask

	task automatic run_case(input bit stall);
		model_inverse();
		send_matrix(stall);
		collect_matrix(stall);
		for (int i = 0; i < n_got; i++)
		begin
			checks++;
			assert (got[i].singular == exp_sing)
			else
			begin
				$display("FAILED %0t out_beat.singular[%0d] expected %b got %b",
					$time, i, exp_sing, got[i].singular);
				errors++;
			end
			if (!exp_sing)
			begin
				checks++;
				assert (got[i].elem == exp_inv[i / n][i % n])
				else
				begin
					$display("FAILED %0t out_beat.elem[%0d][%0d] expected %h got %h",
						$time, i / n, i % n, exp_inv[i / n][i % n], got[i].elem);
					errors++;
				end
			end
		end
	endtask

	task automatic check_known(input int r, input int c, input elem_t want);
		checks++;
		assert (n_got == n*n && got[r*n + c].elem == want)
		else
		begin
			$display("FAILED %0t out_beat.elem[%0d][%0d] expected %h got %h",
				$time, r, c, want, got[r*n + c].elem);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		$display("Test %s finished with %0d error(s)", name, errors - start_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic identity_roundtrip();
		int start_errors;
		start_errors = errors;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				mat_a[r][c] = (r == c) ? ONE : elem_t'(0);
		run_case(1'b0);
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				check_known(r, c, (r == c) ? ONE : elem_t'(0));
		finish_test("identity", start_errors);
	endtask

	task automatic integer_inverse();
		int start_errors;
		start_errors = errors;
		set_row(0, 1, 0, 0, 0, 0);
		set_row(1, 0, 1, 0, 0, 0);
		set_row(2, 0, 0, 1, 2, 3);
		set_row(3, 0, 0, 0, 1, 4);
		set_row(4, 0, 0, 5, 6, 0);
		run_case(1'b0);
		// Lower block inverse is -24 18 5 / 20 -15 -4 / -5 4 1
		check_known(2, 2, int_elem(-24));
		check_known(2, 3, int_elem(18));
		check_known(2, 4, int_elem(5));
		check_known(3, 2, int_elem(20));
		check_known(3, 3, int_elem(-15));
		check_known(3, 4, int_elem(-4));
		check_known(4, 2, int_elem(-5));
		check_known(4, 3, int_elem(4));
		check_known(4, 4, int_elem(1));
		finish_test("integer_inverse", start_errors);
	endtask

	task automatic diagonal_reciprocals();
		int    start_errors;
		elem_t diag [n] = '{16'h0200, 16'h0400, 16'hFE00, 16'h0800, 16'h0080};
		elem_t recip [n] = '{16'h0080, 16'h0040, 16'hFF80, 16'h0020, 16'h0200};
		start_errors = errors;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				mat_a[r][c] = (r == c) ? diag[r] : elem_t'(0);
		run_case(1'b0);
		for (int i = 0; i < n; i++)
			check_known(i, i, recip[i]);
		finish_test("diagonal", start_errors);
	endtask

	task automatic singular_abort();
		int start_errors;
		start_errors = errors;
		set_row(0, 1, 2, 0, 0, 1);
		set_row(1, 0, 1, 3, 0, 0);
		set_row(2, 0, 0, 0, 0, 0);
		set_row(3, 1, 0, 0, 1, 0);
		set_row(4, 0, 0, 1, 0, 1);
		run_case(1'b0);
		// Flag must clear for the next matrix
		set_row(0, 1, 1, 0, 0, 0);
		set_row(1, 0, 1, 1, 0, 0);
		set_row(2, 0, 0, 1, 1, 0);
		set_row(3, 0, 0, 0, 1, 1);
		set_row(4, 0, 0, 0, 0, 1);
		run_case(1'b0);
		finish_test("singular", start_errors);
	endtask

	task automatic backpressure_stream();
		int start_errors;
		start_errors = errors;
		// Product L*U with unit diagonals keeps every pivot at 1
		set_row(0, 1, 2, 0, 1, 0);
		set_row(1, 1, 3, 1, 1, 0);
		set_row(2, 0, 1, 2, 1, 1);
		set_row(3, 2, 4, 1, 4, 2);
		set_row(4, 0, 0, 1, 2, 3);
		run_case(1'b1);
		run_case(1'b1);
		finish_test("backpressure", start_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(96));
		errors    = 0;
		checks    = 0;
		tests     = 0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_beat   = '0;
		out_ready = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		checks++;
		assert (in_ready && !out_valid)
		else
		begin
			$display("FAILED %0t in_ready/out_valid after reset expected 1/0 got %b/%b",
				$time, in_ready, out_valid);
			errors++;
		end
		identity_roundtrip();
		integer_inverse();
		diagonal_reciprocals();
		singular_abort();
		backpressure_stream();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* build.f */
fixp_pkg.sv
matrix_pkg.sv
row_divider.sv
row_eliminator.sv
gauss_jordan_ctrl.sv
matrix_inverter.sv
tb_matrix_inverter.sv

/* Bender.yml */
package:
  name: matrix_inverter

sources:
  - fixp_pkg.sv
  - matrix_pkg.sv
  - row_divider.sv
  - row_eliminator.sv
  - gauss_jordan_ctrl.sv
  - matrix_inverter.sv
  - target: test
    files:
      - tb_matrix_inverter.sv
